// File: tb.f
logic/fetch_pkg.sv
logic/cache_pkg.sv
logic/fetch_unit.sv
logic/icache.sv
logic/instr_mem.sv
logic/fetch_top.sv
tests/tb_clock.sv
tests/fetch_tb.sv

// File: tests/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench of the fetch subsystem
// The program image is random and kept in a local array as well
// Every accepted instruction is checked against that array and against the
// PC order that the decode commands imply

module fetch_tb;

    localparam int mem_words   = 1024;
    localparam int mem_latency = 3;
    localparam int clk_period  = 10;
    localparam logic [31:0] start_pc = 32'h0000_0100;

    // Upper bound on the items accepted over all tests
    localparam int planned_items  = 120;
    localparam int timeout_cycles = mem_words + 16 + planned_items * (mem_latency + 8) + 400;

    wire                      clk;
    logic                     rst_n;
    logic [31:0]              reset_vector;
    logic                     interrupt_pending;
    logic                     dbg_mode;
    wire                      busy;
    wire                      f2d_valid;
    wire fetch_pkg::f2d_type_t f2d_type;
    wire [31:0]               f2d_instr;
    wire [31:0]               f2d_pc;
    logic                     d2f_ready;
    fetch_pkg::d2f_cmd_t      d2f_cmd;
    logic [31:0]              d2f_branchtarget;
    logic                     load_valid;
    logic [31:0]              load_addr;
    logic [31:0]              load_data;

    // Program image as the memory should hold it
    logic [31:0] image [mem_words];
    integer      seed;
    string       test_name = "none";

    // State of the comparison process
    int          accept_count = 0;
    int          irq_count = 0;
    logic        irq_expected = 1'b0;
    logic [31:0] exp_pc;
    logic        branch_pending;
    logic [31:0] branch_target;
    int          older_left;
    logic        offer_held;
    logic [31:0] held_pc;
    logic [31:0] held_instr;

    tb_clock u_clock (
        .clk(clk)
    );

    fetch_top #(
        .mem_words(mem_words),
        .mem_latency(mem_latency)
    ) u_dut (
        .clk, .rst_n, .reset_vector, .interrupt_pending, .dbg_mode, .busy,
        .f2d_valid, .f2d_type, .f2d_instr, .f2d_pc,
        .d2f_ready, .d2f_cmd, .d2f_branchtarget,
        .load_valid, .load_addr, .load_data
    );

    //////////////////////////////////////////////////////////////////////
    // Reference model and helpers
    //////////////////////////////////////////////////////////////////////

    // Word the memory holds at a byte address
    function automatic logic [31:0] expected_instr(input logic [31:0] pc);
        return image[pc / 4];
    endfunction

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    // Write one word through the load port and into the local image
    task automatic load_word(input int idx, input logic [31:0] data);
        @(negedge clk);
        load_valid = 1'b1;
        load_addr  = 32'(idx) << 2;
        load_data  = data;
        image[idx] = data;
    endtask

    // Keep decode running until count more items were taken
    task automatic wait_items(input int count, input bit random_ready);
        int target;
        target = accept_count + count;
        while (accept_count < target) begin
            @(negedge clk);
            if (random_ready) begin
                d2f_ready = 1'($random(seed));
            end
        end
        d2f_ready = 1'b1;
    endtask

    // Branch together with the next instruction that decode takes
    task automatic send_branch(input logic [31:0] target);
        @(negedge clk);
        while (!(f2d_valid && f2d_type == fetch_pkg::f2d_instr)) begin
            @(negedge clk);
        end
        d2f_cmd          = fetch_pkg::d2f_start_branch;
        d2f_branchtarget = target;
        @(negedge clk);
        d2f_cmd = fetch_pkg::d2f_none;
    endtask

    // One cycle of a decode command with no item attached
    task automatic pulse_cmd(input fetch_pkg::d2f_cmd_t cmd, input logic [31:0] target);
        @(negedge clk);
        d2f_cmd          = cmd;
        d2f_branchtarget = target;
        @(negedge clk);
        d2f_cmd = fetch_pkg::d2f_none;
    endtask

    // Enter debug mode and wait for the fetch in flight to drain
    task automatic stop_fetch();
        int waited;
        waited = 0;
        @(negedge clk);
        dbg_mode = 1'b1;
        while (busy && waited < mem_latency + 4) begin
            @(negedge clk);
            waited++;
        end
        assert (!busy) else begin
            $display("busy still high %0d cycles after dbg_mode was set", mem_latency + 4);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Comparison of accepted items
    //////////////////////////////////////////////////////////////////////

    // Outputs are read at the rising edge before the DUT registers move
    always @(posedge clk) begin : compare
        if (!rst_n) begin
            exp_pc         = reset_vector;
            branch_pending = 1'b0;
            older_left     = 0;
            offer_held     = 1'b0;
        end else begin
            // An offer that was refused must come back unchanged
            if (offer_held) begin
                assert (f2d_valid && f2d_pc === held_pc && f2d_instr === held_instr) else begin
                    $display("mismatch test=%s held expected pc=%h instr=%h actual pc=%h instr=%h",
                        test_name, held_pc, held_instr, f2d_pc, f2d_instr);
                    abort_run();
                end
            end
            offer_held = f2d_valid && !d2f_ready && (f2d_type == fetch_pkg::f2d_instr);
            held_pc    = f2d_pc;
            held_instr = f2d_instr;

            if (f2d_valid && d2f_ready) begin
                accept_count++;
                if (f2d_type == fetch_pkg::f2d_interrupt_pending) begin
                    assert (irq_expected) else begin
                        $display("interrupt item offered while no interrupt was raised");
                        abort_run();
                    end
                    irq_count++;
                end else begin
                    assert (f2d_instr === expected_instr(f2d_pc)) else begin
                        $display("mismatch test=%s pc=%h expected=%h actual=%h",
                            test_name, f2d_pc, expected_instr(f2d_pc), f2d_instr);
                        abort_run();
                    end
                    if (branch_pending && f2d_pc == branch_target) begin
                        branch_pending = 1'b0;
                    end else begin
                        // One older item may still come out after a branch
                        assert (f2d_pc === exp_pc && (!branch_pending || older_left > 0)) else begin
                            $display("mismatch test=%s pc expected=%h actual=%h",
                                test_name, branch_pending ? branch_target : exp_pc, f2d_pc);
                            abort_run();
                        end
                        older_left--;
                    end
                    exp_pc = f2d_pc + 32'd4;
                end
            end

            // A branch counts whenever decode is ready even without an item
            if (d2f_ready && d2f_cmd == fetch_pkg::d2f_start_branch) begin
                branch_pending = 1'b1;
                branch_target  = d2f_branchtarget;
                older_left     = 1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin : watchdog
        #(timeout_cycles * clk_period);
        $display("Timeout after %0d cycles, the tests did not complete", timeout_cycles);
        abort_run();
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        logic [31:0] target;
        logic [31:0] base;

        rst_n             = 1'b0;
        reset_vector      = start_pc;
        interrupt_pending = 1'b0;
        dbg_mode          = 1'b0;
        d2f_ready         = 1'b1;
        d2f_cmd           = fetch_pkg::d2f_none;
        d2f_branchtarget  = 32'd0;
        load_valid        = 1'b0;
        load_addr         = 32'd0;
        load_data         = 32'd0;
        seed              = 32'h671f7a66;

        // The image goes in while reset is held and 16 more reset cycles follow
        for (int i = 0; i < mem_words; i++) begin
            load_word(i, $random(seed));
        end
        @(negedge clk);
        load_valid = 1'b0;
        repeat (15) @(negedge clk);
        assert (!f2d_valid && !busy) else begin
            $display("f2d_valid or busy is high while reset is asserted");
            abort_run();
        end
        rst_n = 1'b1;

        // A sequential run from the reset vector is followed by the same range again
        test_name = "sequential";
        wait_items(12, 1'b0);
        send_branch(start_pc);
        wait_items(12, 1'b0);

        // Decode stalls at random
        test_name = "backpressure";
        wait_items(40, 1'b1);

        // Branch to a random aligned address in the lower half of memory
        test_name = "branch";
        target = $random(seed) & 32'h0000_07fc;
        send_branch(target);
        wait_items(16, 1'b0);

        // New words go over the last eight cached lines before a flush and a refetch
        test_name = "flush_reload";
        stop_fetch();
        base = exp_pc - 32'd32;
        for (int i = 0; i < 8; i++) begin
            load_word(base / 4 + i, image[base / 4 + i] ^ ($random(seed) | 32'd1));
        end
        @(negedge clk);
        load_valid = 1'b0;
        pulse_cmd(fetch_pkg::d2f_flush, 32'd0);
        pulse_cmd(fetch_pkg::d2f_start_branch, base);
        dbg_mode = 1'b0;
        wait_items(12, 1'b0);

        // Debug mode stops fetching for good
        test_name = "debug_stop";
        stop_fetch();
        repeat (20) begin
            @(negedge clk);
            assert (!f2d_valid) else begin
                $display("an item was offered while the unit was halted in debug mode");
                abort_run();
            end
        end

        // An interrupt item comes while halted and fetching then picks up where it stopped
        test_name = "interrupt";
        interrupt_pending = 1'b1;
        irq_expected      = 1'b1;
        for (int n = 0; n < 4 && irq_count == 0; n++) begin
            @(negedge clk);
        end
        assert (irq_count > 0) else begin
            $display("no interrupt item was offered while the unit was idle");
            abort_run();
        end
        interrupt_pending = 1'b0;
        irq_expected      = 1'b0;
        dbg_mode          = 1'b0;
        wait_items(16, 1'b0);

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running clock for the testbench, 10 ns period
// The first rising edge comes half a period after time zero
module tb_clock (
    output logic clk
);

    localparam int half_period = 5;

    initial begin
        clk = 1'b0;
    end

    always #(half_period) clk = ~clk;

endmodule

`default_nettype wire

// File: logic/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

// Fetch subsystem, fetch unit in front of the cache in front of the memory

module fetch_top #(
    parameter int line_count  = 16,
    parameter int mem_words   = 1024,
    parameter int mem_latency = 3
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire [31:0]                  reset_vector,
    input  wire                         interrupt_pending,
    input  wire                         dbg_mode,
    output wire                         busy,
    output wire                         f2d_valid,
    output wire fetch_pkg::f2d_type_t   f2d_type,
    output wire [31:0]                  f2d_instr,
    output wire [31:0]                  f2d_pc,
    input  wire                         d2f_ready,
    input  wire fetch_pkg::d2f_cmd_t    d2f_cmd,
    input  wire [31:0]                  d2f_branchtarget,
    input  wire                         load_valid,
    input  wire [31:0]                  load_addr,
    input  wire [31:0]                  load_data
);

    // Fetch to cache
    wire cache_pkg::cache_cmd_t  c_cmd;
    wire [31:0]                  c_address;
    wire                         c_done;
    wire cache_pkg::cache_resp_t c_response;
    wire [31:0]                  c_load_data;

    // Cache to memory
    wire        mem_req_valid;
    wire [31:0] mem_req_addr;
    wire        mem_req_ready;
    wire        mem_resp_valid;
    wire [31:0] mem_resp_data;

    fetch_unit u_fetch (
        .clk, .rst_n, .reset_vector,
        .c_done, .c_response, .c_load_data, .c_cmd, .c_address,
        .interrupt_pending, .dbg_mode, .busy,
        .f2d_valid, .f2d_type, .f2d_instr, .f2d_pc,
        .d2f_ready, .d2f_cmd, .d2f_branchtarget
    );

    icache #(.line_count(line_count)) u_icache (
        .clk, .rst_n,
        .c_cmd, .c_address, .c_done, .c_response, .c_load_data,
        .mem_req_valid, .mem_req_addr, .mem_req_ready, .mem_resp_valid, .mem_resp_data
    );

    instr_mem #(.mem_words(mem_words), .mem_latency(mem_latency)) u_mem (
        .clk, .rst_n, .load_valid, .load_addr, .load_data,
        .mem_req_valid, .mem_req_addr, .mem_req_ready, .mem_resp_valid, .mem_resp_data
    );

endmodule

`default_nettype wire

// File: logic/instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

// Instruction memory with a fixed read latency
// Both address ports carry byte addresses, the word index starts at bit 2
// One read at a time, ready stays low until the answer has gone out

module instr_mem #(
    parameter int mem_words   = 1024,
    parameter int mem_latency = 3
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         load_valid,
    input  wire [31:0]  load_addr,
    input  wire [31:0]  load_data,
    input  wire         mem_req_valid,
    input  wire [31:0]  mem_req_addr,
    output logic        mem_req_ready,
    output logic        mem_resp_valid,
    output logic [31:0] mem_resp_data
);

    localparam int addr_w = $clog2(mem_words);
    // Counter holds at most mem_latency minus one
    localparam int cnt_w  = (mem_latency > 1) ? $clog2(mem_latency) : 1;

    typedef enum logic {
        st_ready,
        st_wait
    } state_t;

    state_t state;
    logic [cnt_w-1:0]  count;
    logic [addr_w-1:0] rd_idx;
    logic              req_take;
    logic [31:0]       mem_q [mem_words];

    assign req_take       = mem_req_valid && mem_req_ready;
    assign mem_req_ready  = state == st_ready;
    // Response cycle is exactly mem_latency cycles after the request
    assign mem_resp_valid = (state == st_wait) && (count == '0);
    assign mem_resp_data  = mem_q[rd_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_ready;
            count <= '0;
        end else begin
            case (state)
                st_ready: begin
                    if (req_take) begin
                        state <= st_wait;
                        count <= cnt_w'(mem_latency - 1);
                    end
                end
                default: begin
                    if (count == '0) begin
                        state <= st_ready;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
            endcase
        end
    end

    // Loads land directly in the array, no handshake
    always_ff @(posedge clk) begin
        if (load_valid) begin
            mem_q[load_addr[addr_w+1:2]] <= load_data;
        end
        if (req_take) begin
            rd_idx <= mem_req_addr[addr_w+1:2];
        end
    end

endmodule

`default_nettype wire

// File: logic/icache.sv
`timescale 1ns/1ps
`default_nettype none

// Direct-mapped instruction cache, one word per line
// A command is captured when it is first presented, then looked up a cycle later
// A miss reads the word from memory, fills the line and looks up again,
// which then hits

module icache #(
    parameter int line_count = 16
) (
    input  wire                         clk,
    input  wire                         rst_n,

    // Requester side
    input  wire cache_pkg::cache_cmd_t  c_cmd,
    input  wire [31:0]                  c_address,
    output logic                        c_done,
    output cache_pkg::cache_resp_t      c_response,
    output logic [31:0]                 c_load_data,

    // Memory side
    output logic                        mem_req_valid,
    output logic [31:0]                 mem_req_addr,
    input  wire                         mem_req_ready,
    input  wire                         mem_resp_valid,
    input  wire [31:0]                  mem_resp_data
);

    // Byte offset is bits 1:0, the index sits right above it
    localparam int idx_w = $clog2(line_count);
    localparam int tag_w = 30 - idx_w;

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_refill
    } state_t;

    state_t state;

    // Captured command, the requester may change c_cmd in the done cycle
    cache_pkg::cache_cmd_t req_cmd;
    logic [31:0] req_addr;
    // Memory read of the current refill was already accepted
    logic req_sent;

    logic [tag_w-1:0]      tag_q [line_count];
    logic [31:0]           data_q [line_count];
    logic [line_count-1:0] valid_q;

    logic [idx_w-1:0] req_idx;
    logic [tag_w-1:0] req_tag;
    logic             hit;
    logic             take;

    assign req_idx = req_addr[idx_w+1:2];
    assign req_tag = req_addr[31:idx_w+2];
    assign hit     = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

    // A flush always finishes in its lookup cycle
    assign c_done      = (state == st_lookup) && ((req_cmd == cache_pkg::cache_flush_all) || hit);
    assign c_response  = cache_pkg::resp_ok;
    assign c_load_data = data_q[req_idx];

    // New commands are taken when idle or right as the previous one ends
    assign take = ((state == st_idle) || c_done) && (c_cmd != cache_pkg::cache_none);

    assign mem_req_valid = (state == st_refill) && !req_sent;
    assign mem_req_addr  = {req_addr[31:2], 2'b00};

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            req_sent <= 1'b0;
            valid_q  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (take) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    // Valid bits drop at the end of the flush done cycle
                    if (req_cmd == cache_pkg::cache_flush_all) begin
                        valid_q <= '0;
                    end
                    if (c_done) begin
                        state <= take ? st_lookup : st_idle;
                    end else begin
                        state    <= st_refill;
                        req_sent <= 1'b0;
                    end
                end
                st_refill: begin
                    if (mem_req_valid && mem_req_ready) begin
                        req_sent <= 1'b1;
                    end
                    if (mem_resp_valid && req_sent) begin
                        valid_q[req_idx] <= 1'b1;
                        state            <= st_lookup;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Captured request and line arrays
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (take) begin
            req_cmd  <= c_cmd;
            req_addr <= c_address;
        end
        // Line fill, the next lookup reads it back
        if ((state == st_refill) && mem_resp_valid) begin
            tag_q[req_idx]  <= req_tag;
            data_q[req_idx] <= mem_resp_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

// Fetch unit
// Sends one cache command at a time and hands each fetched word to decode
// A new command goes out when nothing is active, or when the active fetch
// finished and decode took its result in that same cycle
// Decode commands that show up while a fetch is in flight are remembered
// and served once the fetch is over

module fetch_unit (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire [31:0]                  reset_vector,

    // Cache port
    input  wire                         c_done,
    input  wire cache_pkg::cache_resp_t c_response,
    input  wire [31:0]                  c_load_data,
    output cache_pkg::cache_cmd_t       c_cmd,
    output logic [31:0]                 c_address,

    // Interrupt and debug
    input  wire                         interrupt_pending,
    input  wire                         dbg_mode,
    output logic                        busy,

    // Towards decode
    output logic                        f2d_valid,
    output fetch_pkg::f2d_type_t        f2d_type,
    output logic [31:0]                 f2d_instr,
    output logic [31:0]                 f2d_pc,

    // From decode
    input  wire                         d2f_ready,
    input  wire fetch_pkg::d2f_cmd_t    d2f_cmd,
    input  wire [31:0]                  d2f_branchtarget
);

    // Command and address that were on the cache port last cycle
    cache_pkg::cache_cmd_t active_cmd;
    logic [31:0] pc;

    // Word that decode did not take yet
    logic [31:0] saved_data;
    logic [31:0] saved_data_nxt;
    logic        saved_valid;
    logic        saved_valid_nxt;

    // Decode commands waiting for the current fetch to end
    logic        branched;
    logic        branched_nxt;
    logic [31:0] branched_target;
    logic [31:0] branched_target_nxt;
    logic        flushed;
    logic        flushed_nxt;

    // Low during reset and the first cycle after it
    logic run_en;

    logic        active;
    logic        exec_done;
    logic        fetch_err;
    logic        d2f_branch;
    logic        d2f_flush_cmd;
    logic        flushing;
    logic        branching;
    logic        can_issue;
    logic [31:0] branching_target;
    logic [31:0] pc_plus_4;

    assign active    = active_cmd != cache_pkg::cache_none;
    assign exec_done = active && c_done && (active_cmd == cache_pkg::cache_execute);
    // Failed fetches are retried at the same address
    assign fetch_err = exec_done && (c_response != cache_pkg::resp_ok);

    assign d2f_branch    = d2f_ready && (d2f_cmd == fetch_pkg::d2f_start_branch);
    assign d2f_flush_cmd = d2f_ready && (d2f_cmd == fetch_pkg::d2f_flush);

    // Pending means either remembered earlier or arriving right now
    assign flushing         = flushed || d2f_flush_cmd;
    assign branching        = branched || d2f_branch;
    assign branching_target = d2f_branch ? d2f_branchtarget : branched_target;
    assign pc_plus_4        = pc + 32'd4;

    assign busy = active;

    // Next command may go out unless a fetch is still running or decode stalls
    // on a word that is offered right now
    assign can_issue = run_en
        && !(active && !c_done)
        && !(saved_valid && !d2f_ready)
        && !(exec_done && !fetch_err && !d2f_ready);

    //////////////////////////////////////////////////////////////////////
    // Offer to decode and next cache command
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        c_cmd     = cache_pkg::cache_none;
        c_address = pc;
        f2d_valid = 1'b0;
        f2d_type  = fetch_pkg::f2d_instr;
        f2d_instr = c_load_data;
        f2d_pc    = pc;

        saved_data_nxt      = saved_data;
        saved_valid_nxt     = saved_valid;
        branched_nxt        = branched;
        branched_target_nxt = branched_target;
        flushed_nxt         = flushed;

        // A saved word always goes first, pc still points at it
        if (saved_valid) begin
            f2d_valid       = 1'b1;
            f2d_instr       = saved_data;
            saved_valid_nxt = !d2f_ready;
        end else if (exec_done && !fetch_err) begin
            // Straight from the cache, kept if decode is not ready
            f2d_valid       = 1'b1;
            saved_valid_nxt = !d2f_ready;
            saved_data_nxt  = c_load_data;
        end else if (!active && interrupt_pending && run_en) begin
            // Nothing active and nothing saved
            f2d_valid = 1'b1;
            f2d_type  = fetch_pkg::f2d_interrupt_pending;
        end

        // Every accepted decode command is noted first
        // Issuing below clears what it serves
        if (d2f_flush_cmd) begin
            flushed_nxt = 1'b1;
        end
        if (d2f_branch) begin
            branched_nxt        = 1'b1;
            branched_target_nxt = d2f_branchtarget;
        end

        if (active && !c_done) begin
            // Keep the command and address steady until the cache answers
            c_cmd = active_cmd;
        end else if (can_issue && !dbg_mode) begin
            if (flushing) begin
                c_cmd       = cache_pkg::cache_flush_all;
                flushed_nxt = 1'b0;
            end else if (branching) begin
                c_cmd        = cache_pkg::cache_execute;
                c_address    = branching_target;
                branched_nxt = 1'b0;
            end else begin
                c_cmd     = cache_pkg::cache_execute;
                c_address = fetch_err ? pc : pc_plus_4;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // State registers
    //////////////////////////////////////////////////////////////////////

    // Reset acts like a taken branch to reset_vector, so the first
    // fetch comes out of the normal branch path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_cmd      <= cache_pkg::cache_none;
            saved_valid     <= 1'b0;
            branched        <= 1'b1;
            branched_target <= reset_vector;
            flushed         <= 1'b0;
            run_en          <= 1'b0;
        end else begin
            active_cmd      <= c_cmd;
            saved_valid     <= saved_valid_nxt;
            branched        <= branched_nxt;
            branched_target <= branched_target_nxt;
            flushed         <= flushed_nxt;
            run_en          <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        pc         <= c_address;
        saved_data <= saved_data_nxt;
    end

endmodule

`default_nettype wire

// File: logic/cache_pkg.sv
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Command and response encodings of the cache port
//////////////////////////////////////////////////////////////////////

package cache_pkg;

    // Command presented by the requester
    // A command other than none is held with its address until c_done
    // The next command may already be presented in the c_done cycle
    typedef enum logic [1:0] {
        cache_none      = 2'd0,
        cache_execute   = 2'd1,
        cache_flush_all = 2'd2
    } cache_cmd_t;

    // Response that comes with c_done
    // The instruction cache here never fails, so it answers ok every time
    typedef enum logic [1:0] {
        resp_ok    = 2'd0,
        resp_error = 2'd1
    } cache_resp_t;

endpackage

`default_nettype wire

// File: logic/fetch_pkg.sv
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Encodings shared between the fetch unit and the decode stage
//////////////////////////////////////////////////////////////////////

package fetch_pkg;

    // Kind of item that fetch offers to decode
    // An instruction item carries the fetched word and its PC
    // An interrupt item carries no valid instruction, it only tells decode
    // that an interrupt is waiting while fetch has nothing else to offer
    typedef enum logic [0:0] {
        f2d_instr             = 1'b0,
        f2d_interrupt_pending = 1'b1
    } f2d_type_t;

    // Commands that decode sends back to fetch
    // Decode qualifies them with d2f_ready, they are ignored otherwise
    // A flush empties the instruction cache before the next fetch
    typedef enum logic [1:0] {
        d2f_none         = 2'd0,
        d2f_start_branch = 2'd1,
        d2f_flush        = 2'd2
    } d2f_cmd_t;

endpackage

`default_nettype wire
